// File: include/synth_ctrl_defs.svh
`ifndef SYNTH_CTRL_DEFS_SVH
`define SYNTH_CTRL_DEFS_SVH

// size of the voice bank
`define SC_VOICES  8    // voice slots
`define SC_V_WIDTH 3    // bits to index a slot

// SC_V_WIDTH must cover SC_VOICES; active_keys is one bit wider
// so that a full bank can be counted

`endif

// File: hw/midi_pkg.sv
package midi_pkg;

    // raw byte as it comes off the cpu byte port
    typedef logic [7:0] midi_byte_t;

    // channel nibble of a channel voice status
    typedef logic [3:0] midi_ch_t;

    // 7 bit payload of a data byte, key or velocity
    typedef logic [6:0] midi_data_t;

    // running status classes
    // two-byte other covers poly pressure, control change and pitch bend
    // one-byte other covers program change and channel pressure
    typedef enum logic [2:0] {
        KIND_NONE     = 3'd0,   // no status or other channel
        KIND_NOTE_OFF = 3'd1,   // 0x8n
        KIND_NOTE_ON  = 3'd2,   // 0x9n
        KIND_TWO      = 3'd3,   // 0xAn, 0xBn, 0xEn
        KIND_ONE      = 3'd4,   // 0xCn, 0xDn
        KIND_SYSEX    = 3'd5    // 0xF0 until next status
    } midi_kind_e;

    // one complete note message from the parser
    // on is low for note-off and for note-on with velocity 0
    typedef struct packed {
        logic       on;         // note on / note off
        midi_data_t key;        // note number
        midi_data_t velocity;   // attack or release velocity
    } note_msg_t;

endpackage

// File: hw/voice_pkg.sv
`include "synth_ctrl_defs.svh"

package voice_pkg;

    import midi_pkg::*;

    // index of one voice slot
    typedef logic [`SC_V_WIDTH-1:0] voice_idx_t;

    // command written by the allocator into one slot
    // start and rel are never set together
    typedef struct packed {
        logic       start;      // claim slot, note on
        logic       rel;        // release slot, note off
        midi_data_t key;        // note number
        midi_data_t velocity;   // velocity for the event
    } slot_cmd_t;

    // event toward the synth engine
    typedef struct packed {
        logic       on;         // 1 = voice starts, 0 = voice released
        voice_idx_t voice;      // slot that owns the note
        midi_data_t key;        // note number
        midi_data_t velocity;   // attack or release velocity
    } voice_evt_t;

endpackage

// File: hw/midi_parser.sv
`timescale 1ns/1ps

module midi_parser
    import midi_pkg::*;
(
    input  logic       reg_clk,
    input  logic       rst,
    input  midi_ch_t   midi_ch,      // channel the engine listens to
    input  logic       midi_req,     // four phase byte port
    input  midi_byte_t midi_byte,
    output logic       midi_ack,
    output logic       msg_valid,    // note message to allocator
    output note_msg_t  msg,
    input  logic       msg_take
);

    typedef enum logic [1:0] {
        ST_IDLE,        // waiting for midi_req
        ST_ACK,         // first cycle with ack high
        ST_WAIT_LOW,    // ack high, waiting for req to drop
        ST_HOLD         // message still held, no new byte taken
    } hs_state_e;

    hs_state_e  state;
    midi_kind_e kind;           // running status
    logic       data_cnt;       // odd data byte seen
    midi_data_t first_data;     // key of current note
    midi_kind_e new_kind;
    logic       take_byte;
    logic       is_status;
    logic       is_rt;
    logic       is_sys;
    logic       msg_pend;

    assign take_byte = (state == ST_IDLE) && midi_req;
    assign is_status = midi_byte[7];
    assign is_rt     = (midi_byte[7:3] == 5'b11111);    // 0xF8..0xFF
    assign is_sys    = (midi_byte[7:4] == 4'hF);
    assign msg_pend  = msg_valid && !msg_take;          // still held after this edge

    // status byte classification
    always_comb begin
        new_kind = KIND_NONE;
        if (is_sys) begin
            new_kind = (midi_byte == 8'hF0) ? KIND_SYSEX : KIND_NONE;
        end else if (midi_byte[3:0] == midi_ch) begin
            case (midi_byte[6:4])
                3'd0:    new_kind = KIND_NOTE_OFF;
                3'd1:    new_kind = KIND_NOTE_ON;
                3'd4,
                3'd5:    new_kind = KIND_ONE;   // prog change, ch pressure
                default: new_kind = KIND_TWO;   // poly pressure, ctrl, pitch
            endcase
        end
    end

    always_ff @(posedge reg_clk) begin
        if (rst) begin
            state     <= ST_IDLE;
            midi_ack  <= 1'b0;
            msg_valid <= 1'b0;
            kind      <= KIND_NONE;
            data_cnt  <= 1'b0;
        end else begin
            if (msg_take) msg_valid <= 1'b0;        // allocator has it
            case (state)
                ST_IDLE: begin
                    if (midi_req) begin
                        midi_ack <= 1'b1;
                        state    <= ST_ACK;
                        if (is_status && !is_rt) begin
                            kind     <= new_kind;   // real-time leaves status alone
                            data_cnt <= 1'b0;
                        end else if (!is_status) begin
                            case (kind)
                                KIND_NOTE_OFF,
                                KIND_NOTE_ON: begin
                                    data_cnt <= !data_cnt;
                                    if (data_cnt) msg_valid <= 1'b1;  // velocity byte
                                end
                                KIND_TWO: data_cnt <= !data_cnt;     // counted then dropped
                                default: ;                           // one-byte, sysex, none
                            endcase
                        end
                    end
                end
                ST_ACK,
                ST_WAIT_LOW: begin
                    if (!midi_req) begin
                        midi_ack <= 1'b0;
                        state    <= msg_pend ? ST_HOLD : ST_IDLE;
                    end else begin
                        state <= ST_WAIT_LOW;
                    end
                end
                ST_HOLD: if (msg_take) state <= ST_IDLE;    // back-pressure ends
                default: state <= ST_IDLE;
            endcase
        end
    end

    // note payload stays stable while msg_valid is high
    always_ff @(posedge reg_clk) begin
        if (take_byte && !is_status) begin
            if (!data_cnt) first_data <= midi_byte[6:0];
            if (data_cnt) begin
                msg.on       <= (kind == KIND_NOTE_ON) && (midi_byte[6:0] != '0);
                msg.key      <= first_data;
                msg.velocity <= midi_byte[6:0];
            end
        end
    end

    // ack only answers a request and never rises while a message is held
    a_ack_after_req: assert property (@(posedge reg_clk) disable iff (rst)
        $rose(midi_ack) |-> $past(midi_req) && !$past(msg_valid));

endmodule

// File: hw/voice_alloc.sv
`timescale 1ns/1ps
`include "synth_ctrl_defs.svh"

module voice_alloc
    import midi_pkg::*, voice_pkg::*;
(
    input  logic                   reg_clk,
    input  logic                   rst,
    input  logic                   msg_valid,
    input  note_msg_t              msg,
    output logic                   msg_take,    // one cycle pulse
    input  logic [`SC_VOICES-1:0]  busy,
    input  logic [`SC_VOICES-1:0]  pend,
    input  midi_data_t             key_held [`SC_VOICES],
    output logic [`SC_VOICES-1:0]  cmd_en,      // one-hot slot select
    output slot_cmd_t              cmd,
    output logic [`SC_VOICES-1:0]  keys_on,
    output logic [`SC_V_WIDTH:0]   active_keys
);

    voice_idx_t on_idx;     // lowest free slot
    voice_idx_t off_idx;    // lowest slot holding msg.key
    logic       on_hit;
    logic       off_hit;
    voice_idx_t tgt_idx;
    logic       tgt_hit;

    function automatic logic [`SC_V_WIDTH:0] count_ones(logic [`SC_VOICES-1:0] v);
        logic [`SC_V_WIDTH:0] n;
        n = '0;
        for (int i = 0; i < `SC_VOICES; i++)
            n = n + (`SC_V_WIDTH+1)'(v[i]);
        return n;
    endfunction

    // priority encoders where the last write wins so lowest index is kept
    always_comb begin
        on_idx  = '0;
        off_idx = '0;
        on_hit  = 1'b0;
        off_hit = 1'b0;
        for (int i = `SC_VOICES-1; i >= 0; i--) begin
            if (!busy[i]) begin
                on_hit = 1'b1;
                on_idx = voice_idx_t'(i);
            end
            if (busy[i] && (key_held[i] == msg.key)) begin
                off_hit = 1'b1;
                off_idx = voice_idx_t'(i);
            end
        end
    end

    assign tgt_idx = msg.on ? on_idx : off_idx;
    assign tgt_hit = msg.on ? on_hit : off_hit;    // no hit means full bank or unknown key

    always_ff @(posedge reg_clk) begin
        if (rst) begin
            msg_take    <= 1'b0;
            cmd_en      <= '0;
            active_keys <= '0;
        end else begin
            msg_take    <= 1'b0;
            cmd_en      <= '0;
            active_keys <= count_ones(busy);
            if (msg_valid && !msg_take) begin       // skip the cycle after a take
                if (!tgt_hit) begin
                    msg_take <= 1'b1;               // dropped but still consumed
                end else if (!pend[tgt_idx]) begin  // wait for slot event to drain
                    msg_take <= 1'b1;
                    cmd_en   <= `SC_VOICES'(1) << tgt_idx;
                end
            end
        end
    end

    always_ff @(posedge reg_clk) begin
        cmd.start    <= msg.on;
        cmd.rel      <= !msg.on;
        cmd.key      <= msg.key;
        cmd.velocity <= msg.velocity;
    end

    assign keys_on = busy;

    // one slot with no event waiting
    // a start lands on a free slot and a release on a busy one
    a_cmd_onehot: assert property (@(posedge reg_clk) disable iff (rst)
        |cmd_en |-> $onehot(cmd_en) && !(|(cmd_en & pend)) &&
                    (cmd.start ? !(|(cmd_en & busy)) : |(cmd_en & busy)));

endmodule

// File: hw/voice_slot.sv
`timescale 1ns/1ps

module voice_slot
    import midi_pkg::*, voice_pkg::*;
#(
    parameter int IDX = 0       // own slot number
) (
    input  logic       reg_clk,
    input  logic       rst,
    input  logic       cmd_en,      // this slot selected
    input  slot_cmd_t  cmd,
    output logic       busy,        // voice sounding
    output midi_data_t key_held,
    output logic       pend,        // event waiting for arbiter
    output voice_evt_t evt,
    input  logic       clr          // arbiter took the event
);

    logic       evt_on;     // kind of pending event
    midi_data_t vel_q;      // attack or release velocity

    always_ff @(posedge reg_clk) begin
        if (rst) begin
            busy <= 1'b0;
            pend <= 1'b0;
        end else begin
            if (clr) pend <= 1'b0;
            if (cmd_en && cmd.start) begin
                busy <= 1'b1;
                pend <= 1'b1;               // note on event
            end else if (cmd_en && cmd.rel) begin
                busy <= 1'b0;
                pend <= 1'b1;               // note off event
            end
        end
    end

    always_ff @(posedge reg_clk) begin
        if (cmd_en) begin
            if (cmd.start) key_held <= cmd.key; // release keeps the held key
            vel_q  <= cmd.velocity;
            evt_on <= cmd.start;
        end
    end

    assign evt.on       = evt_on;
    assign evt.voice    = voice_idx_t'(IDX);
    assign evt.key      = key_held;
    assign evt.velocity = vel_q;

endmodule

// File: hw/voice_evt_arb.sv
`timescale 1ns/1ps
`include "synth_ctrl_defs.svh"

module voice_evt_arb
    import voice_pkg::*;
(
    input  logic                  reg_clk,
    input  logic                  rst,
    input  logic [`SC_VOICES-1:0] pend,
    input  voice_evt_t            slot_evt [`SC_VOICES],
    output logic [`SC_VOICES-1:0] clr,          // one-hot pend clear
    output logic                  evt_req,      // four phase event port
    output voice_evt_t            evt,
    input  logic                  evt_ack
);

    typedef enum logic [1:0] {
        ARB_IDLE,       // look for pending slots
        ARB_REQ,        // req high until ack
        ARB_ACK_LOW     // wait for ack to drop
    } arb_state_e;

    arb_state_e state;
    voice_idx_t last_q;     // current / last granted slot
    voice_idx_t gnt_idx;
    logic       gnt_hit;

    // round robin search starts one past the last grant
    always_comb begin : rr_search
        int pos;
        gnt_hit = 1'b0;
        gnt_idx = last_q;
        for (int k = `SC_VOICES; k >= 1; k--) begin
            pos = (int'(last_q) + k) % `SC_VOICES;
            if (pend[pos]) begin
                gnt_hit = 1'b1;
                gnt_idx = voice_idx_t'(pos);    // nearest wins since it is written last
            end
        end
    end

    always_ff @(posedge reg_clk) begin
        if (rst) begin
            state   <= ARB_IDLE;
            evt_req <= 1'b0;
            last_q  <= voice_idx_t'(`SC_VOICES-1);  // slot 0 goes first
        end else begin
            case (state)
                ARB_IDLE: begin
                    if (gnt_hit) begin
                        evt_req <= 1'b1;
                        last_q  <= gnt_idx;
                        state   <= ARB_REQ;
                    end
                end
                ARB_REQ: begin
                    if (evt_ack) begin
                        evt_req <= 1'b0;
                        state   <= ARB_ACK_LOW;
                    end
                end
                ARB_ACK_LOW: if (!evt_ack) state <= ARB_IDLE;
                default:     state <= ARB_IDLE;
            endcase
        end
    end

    // latched copy since the slot may be rewritten once pend clears
    always_ff @(posedge reg_clk) begin
        if (state == ARB_IDLE && gnt_hit) evt <= slot_evt[gnt_idx];
    end

    assign clr = (state == ARB_REQ && evt_ack) ? (`SC_VOICES'(1) << last_q) : '0;

    // event held steady and owned by the granted slot until ack
    a_evt_stable: assert property (@(posedge reg_clk) disable iff (rst)
        $past(evt_req) && evt_req |->
            $stable(evt) && pend[last_q] && (evt.voice == last_q));

endmodule

// File: hw/synth_controller.sv
`timescale 1ns/1ps
`include "synth_ctrl_defs.svh"

module synth_controller
    import midi_pkg::*, voice_pkg::*;
(
    input  logic                  reg_clk,
    input  logic                  rst,
    input  midi_ch_t              midi_ch,      // from synth engine
    input  logic                  midi_req,     // cpu byte port
    input  midi_byte_t            midi_byte,
    output logic                  midi_ack,
    output logic                  evt_req,      // voice events to engine
    output voice_evt_t            evt,
    input  logic                  evt_ack,
    output logic [`SC_VOICES-1:0] keys_on,
    output logic [`SC_V_WIDTH:0]  active_keys
);

    logic                  msg_valid;
    note_msg_t             msg;
    logic                  msg_take;
    logic [`SC_VOICES-1:0] busy;
    logic [`SC_VOICES-1:0] pend;
    midi_data_t            key_held [`SC_VOICES];
    logic [`SC_VOICES-1:0] cmd_en;
    slot_cmd_t             cmd;         // shared, cmd_en picks the slot
    voice_evt_t            slot_evt [`SC_VOICES];
    logic [`SC_VOICES-1:0] clr;

    midi_parser i_midi_parser (
        .reg_clk   (reg_clk),
        .rst       (rst),
        .midi_ch   (midi_ch),
        .midi_req  (midi_req),
        .midi_byte (midi_byte),
        .midi_ack  (midi_ack),
        .msg_valid (msg_valid),
        .msg       (msg),
        .msg_take  (msg_take)
    );

    voice_alloc i_voice_alloc (
        .reg_clk     (reg_clk),
        .rst         (rst),
        .msg_valid   (msg_valid),
        .msg         (msg),
        .msg_take    (msg_take),
        .busy        (busy),
        .pend        (pend),
        .key_held    (key_held),
        .cmd_en      (cmd_en),
        .cmd         (cmd),
        .keys_on     (keys_on),
        .active_keys (active_keys)
    );

    for (genvar i = 0; i < `SC_VOICES; i++) begin : g_slot
        voice_slot #(.IDX(i)) i_voice_slot (
            .reg_clk  (reg_clk),
            .rst      (rst),
            .cmd_en   (cmd_en[i]),
            .cmd      (cmd),
            .busy     (busy[i]),
            .key_held (key_held[i]),
            .pend     (pend[i]),
            .evt      (slot_evt[i]),
            .clr      (clr[i])
        );
    end

    voice_evt_arb i_voice_evt_arb (
        .reg_clk  (reg_clk),
        .rst      (rst),
        .pend     (pend),
        .slot_evt (slot_evt),
        .clr      (clr),
        .evt_req  (evt_req),
        .evt      (evt),
        .evt_ack  (evt_ack)
    );

endmodule

// File: dv/tb_synth_controller.sv
`timescale 1ns/1ps
`include "synth_ctrl_defs.svh"

module tb_synth_controller
    import midi_pkg::*, voice_pkg::*;
();

    localparam int       MAX_CYCLES   = 20000;     // all six tests need a few thousand
    localparam int       QUIET_CYCLES = 16;        // idle window that ends a test step
    localparam midi_ch_t CH           = 4'd3;      // channel the engine listens to

    logic                  reg_clk = 1'b0;
    logic                  rst;
    midi_ch_t              midi_ch;
    logic                  midi_req;
    midi_byte_t            midi_byte;
    logic                  midi_ack;
    logic                  evt_req;
    voice_evt_t            evt;
    logic                  evt_ack;
    logic [`SC_VOICES-1:0] keys_on;
    logic [`SC_V_WIDTH:0]  active_keys;

    logic [31:0]           lfsr       = 32'h86e50b66;
    logic                  slow_ack   = 1'b0;      // long engine delays
    int                    cycles     = 0;
    int                    err_cnt    = 0;
    int                    check_cnt  = 0;
    int                    ack_wait   = 0;         // extra cycles before last midi_ack
    logic [17:0]           exp_q [$];              // predicted voice events
    logic [17:0]           got_q [$];              // events seen on the port
    logic [`SC_VOICES-1:0] model_busy = '0;        // reference voice bank
    logic [6:0]            model_key [`SC_VOICES];

    synth_controller i_synth_controller (
        .reg_clk     (reg_clk),
        .rst         (rst),
        .midi_ch     (midi_ch),
        .midi_req    (midi_req),
        .midi_byte   (midi_byte),
        .midi_ack    (midi_ack),
        .evt_req     (evt_req),
        .evt         (evt),
        .evt_ack     (evt_ack),
        .keys_on     (keys_on),
        .active_keys (active_keys)
    );

    always #20 reg_clk = ~reg_clk;                 // 40 ns period

    always @(posedge reg_clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout after %0d cycles, a handshake never completed", cycles);
            $display("TB FAILED");
            $finish;
        end
    end

    // galois form, taps x^32 x^22 x^2 x 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    function automatic int rand_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);                // one step per bit
            v = (v << 1) | int'(lfsr[0]);
        end
        return v;
    endfunction

    function automatic string evt_str(input logic [17:0] e);
        return $sformatf("on=%0b voice=%0d key=%0d vel=%0d", e[17], e[16:14], e[13:7], e[6:0]);
    endfunction

    // lowest free slot for note-on, lowest matching busy slot for note-off
    task automatic model_note(input logic on, input logic [6:0] key, input logic [6:0] vel);
        int slot;
        slot = -1;
        for (int i = 0; i < `SC_VOICES; i++) begin
            if (slot < 0 && on && !model_busy[i])
                slot = i;
            if (slot < 0 && !on && model_busy[i] && model_key[i] == key)
                slot = i;
        end
        if (slot >= 0) begin                       // otherwise dropped, no event
            model_busy[slot] = on;
            if (on)
                model_key[slot] = key;
            exp_q.push_back({on, slot[`SC_V_WIDTH-1:0], key, vel});
        end
    endtask

    // four phase byte port, source side
    task automatic send_byte(input logic [7:0] b);
        @(posedge reg_clk);
        midi_byte <= b;
        midi_req  <= 1'b1;
        ack_wait = 0;
        @(negedge reg_clk);
        while (!midi_ack) begin
            ack_wait++;                            // back-pressure shows up here
            @(negedge reg_clk);
        end
        @(posedge reg_clk);
        midi_req <= 1'b0;
        @(negedge reg_clk);
        while (midi_ack)
            @(negedge reg_clk);
    endtask

    // status 0 keeps the running status
    task automatic note(input logic [7:0] status, input logic is_on,
                        input logic [6:0] key, input logic [6:0] vel);
        if (status != 8'h00)
            send_byte(status);
        send_byte({1'b0, key});
        send_byte({1'b0, vel});
        model_note(is_on && (vel != 7'd0), key, vel);  // velocity 0 means release
    endtask

    // wait for the event port to go idle, then compare with the model
    task automatic check_state();
        int quiet;
        int idx;
        int exp_cnt;
        quiet = 0;
        while (quiet < QUIET_CYCLES) begin
            @(negedge reg_clk);
            quiet = (evt_req || evt_ack) ? 0 : quiet + 1;
        end
        while (exp_q.size() > 0) begin             // multiset match, arbiter is round robin
            idx = -1;
            foreach (got_q[i]) begin
                if (idx < 0 && got_q[i] == exp_q[0])
                    idx = i;
            end
            check_cnt++;
            if (idx < 0) begin
                $display("%0t: expected event never arrived, %s", $time, evt_str(exp_q[0]));
                err_cnt++;
            end else begin
                got_q.delete(idx);
            end
            void'(exp_q.pop_front());
        end
        foreach (got_q[i]) begin
            $display("%0t: event that should not exist, %s", $time, evt_str(got_q[i]));
            err_cnt++;
        end
        got_q.delete();
        exp_cnt = $countones(model_busy);
        check_cnt += 2;
        if (keys_on !== model_busy) begin
            $display("ERR %0t keys_on expected %h got %h", $time, model_busy, keys_on);
            err_cnt++;
        end
        if (active_keys !== (`SC_V_WIDTH+1)'(exp_cnt)) begin
            $display("ERR %0t active_keys expected %0d got %0d", $time, exp_cnt, active_keys);
            err_cnt++;
        end
    endtask

    task automatic report(input string name, input int errs_before);
        if (err_cnt == errs_before) begin
            $display("%0t %s: ok", $time, name);
        end else begin
            $display("%0t %s: %0d errors", $time, name, err_cnt - errs_before);
        end
    endtask

    task automatic test_note_on();
        int e0;
        e0 = err_cnt;
        check_cnt += 2;
        if (midi_ack !== 1'b0) begin
            $display("ERR %0t midi_ack expected 0 got %b", $time, midi_ack);
            err_cnt++;
        end
        if (evt_req !== 1'b0) begin
            $display("ERR %0t evt_req expected 0 got %b", $time, evt_req);
            err_cnt++;
        end
        note({4'h9, CH}, 1'b1, 7'd60, 7'd100);     // lands in voice 0
        check_state();
        report("test1 note_on", e0);
    endtask

    task automatic test_running_status();
        int e0;
        e0 = err_cnt;
        note(8'h00, 1'b1, 7'd64, 7'd90);           // no status byte, voice 1
        note(8'h00, 1'b1, 7'd60, 7'd0);            // velocity 0 releases voice 0
        note({4'h8, CH}, 1'b0, 7'd64, 7'd50);      // true note-off
        check_state();
        report("test2 running_status", e0);
    endtask

    task automatic test_channel_filter();
        int e0;
        e0 = err_cnt;
        note({4'h9, CH}, 1'b1, 7'd55, 7'd64);      // held across the filtered traffic
        check_state();
        send_byte({4'h9, 4'd5});                   // other channel
        send_byte(8'd70);
        send_byte(8'd80);
        send_byte({4'h8, 4'd5});                   // must not release key 55
        send_byte(8'd55);
        send_byte(8'd0);
        send_byte({4'hB, CH});                     // control change
        send_byte(8'd7);
        send_byte(8'd100);
        send_byte({4'hC, CH});                     // program change
        send_byte(8'd5);
        check_state();
        note({4'h9, CH}, 1'b1, 7'd72, 7'd70);
        note(8'h00, 1'b1, 7'd72, 7'd0);
        note(8'h00, 1'b1, 7'd55, 7'd0);
        check_state();
        report("test3 channel_filter", e0);
    endtask

    task automatic test_full_bank();
        int e0;
        e0 = err_cnt;
        for (int i = 0; i < 9; i++) begin
            note((i == 0) ? {4'h9, CH} : 8'h00, 1'b1, 7'(40 + i), 7'(20 + i));
        end
        check_state();                             // ninth note dropped
        note({4'h8, CH}, 1'b0, 7'd100, 7'd10);     // key not held
        check_state();
        for (int i = 0; i < 8; i++) begin
            note(8'h00, 1'b0, 7'(40 + i), 7'd30);
        end
        check_state();
        report("test4 full_bank", e0);
    endtask

    task automatic test_back_pressure();
        int e0;
        e0 = err_cnt;
        slow_ack = 1'b1;
        note({4'h9, CH}, 1'b1, 7'd60, 7'd100);
        note({4'h8, CH}, 1'b0, 7'd60, 7'd40);      // voice 0 still pending, held
        send_byte({4'h9, CH});
        check_cnt++;
        if (ack_wait <= 20) begin
            $display("%0t: midi_ack did not stall behind a pending voice event (%0d cycles)",
                     $time, ack_wait);
            err_cnt++;
        end
        send_byte(8'd62);
        send_byte(8'd101);
        model_note(1'b1, 7'd62, 7'd101);
        note(8'h00, 1'b1, 7'd64, 7'd102);
        note(8'h00, 1'b1, 7'd62, 7'd0);
        note(8'h00, 1'b1, 7'd64, 7'd0);
        check_state();
        slow_ack = 1'b0;
        report("test5 back_pressure", e0);
    endtask

    task automatic test_realtime();
        int e0;
        e0 = err_cnt;
        send_byte({4'h9, CH});
        send_byte(8'd65);
        send_byte(8'hF8);                          // timing clock between data bytes
        send_byte(8'd110);
        model_note(1'b1, 7'd65, 7'd110);
        check_state();
        note(8'h00, 1'b1, 7'd65, 7'd0);            // running status survives 0xF8
        check_state();
        report("test6 realtime", e0);
    endtask

    // engine side of the event port
    initial begin : evt_collector
        logic [17:0] seen;
        int          delay;
        evt_ack <= 1'b0;
        forever begin
            @(negedge reg_clk);
            if (evt_req === 1'b1 && !evt_ack) begin
                seen  = evt;
                delay = slow_ack ? 64 + rand_bits(6) : rand_bits(2);
                repeat (delay)
                    @(negedge reg_clk);
                check_cnt++;
                if (evt !== seen) begin            // must hold while req is high
                    $display("ERR %0t evt expected %h got %h", $time, seen, evt);
                    err_cnt++;
                end
                got_q.push_back(evt);
                @(posedge reg_clk);
                evt_ack <= 1'b1;
                @(negedge reg_clk);
                while (evt_req)
                    @(negedge reg_clk);
                @(posedge reg_clk);
                evt_ack <= 1'b0;
            end
        end
    end

    initial begin : main
        rst       <= 1'b1;
        midi_ch   <= CH;
        midi_req  <= 1'b0;
        midi_byte <= 8'h00;
        repeat (10) @(posedge reg_clk);
        rst <= 1'b0;
        @(negedge reg_clk);
        test_note_on();
        test_running_status();
        test_channel_filter();
        test_full_bank();
        test_back_pressure();
        test_realtime();
        $display("tests 6, checks %0d, errors %0d", check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: synth_controller.f
+incdir+include
hw/midi_pkg.sv
hw/voice_pkg.sv
hw/midi_parser.sv
hw/voice_alloc.sv
hw/voice_slot.sv
hw/voice_evt_arb.sv
hw/synth_controller.sv
dv/tb_synth_controller.sv

// File: run_sim.sh
#!/bin/sh
# build and run the synth_controller testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_synth_controller \
    -f synth_controller.f

# keep the output even when the simulation exits with an error
out=$(./obj_dir/Vtb_synth_controller 2>&1) || true
echo "$out"

echo "$out" | grep -qx "TB PASSED"
